// ==== Bender.yml ====
package:
  name: mct

sources:
  - mct_pkg.sv
  - mct_icache.sv
  - mct_req_decode.sv
  - mct_byte_seq.sv
  - mct_word_assemble.sv
  - mct_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_byte_ram.sv
      - tb_mct.sv

// ==== mct.f ====
mct_pkg.sv
mct_icache.sv
mct_req_decode.sv
mct_byte_seq.sv
mct_word_assemble.sv
mct_top.sv
tb_clk_gen.sv
tb_byte_ram.sv
tb_mct.sv

// ==== mct_byte_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module mct_byte_seq import mct_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       start_i,
  input  mem_req_t   req_i,
  output logic       busy_o,
  output addr_t      ram_a_o,
  output logic       ram_wr_o,
  output byte_t      ram_d_o,
  output logic       cap_o,
  output logic [1:0] cap_lane_o,
  output req_kind_e  cap_kind_o,
  output addr_t      cap_addr_o,
  output logic       finish_o,
  output logic       inval_o,
  output addr_t      inval_addr_o
);

  seq_state_e state_q;
  seq_state_e state_d;
  mem_req_t   req_q;
  logic [1:0] cnt_q;
  logic [1:0] cnt_nxt;
  req_kind_e  kind_cur;
  logic       reading;

  assign busy_o   = (state_q != SEQ_IDLE);
  assign kind_cur = busy_o ? req_q.kind : req_i.kind;
  assign reading  = (kind_cur != REQ_STORE);
  assign cnt_nxt  = cnt_q + 2'd1;

  // snoop the cache as soon as a store is taken
  assign inval_o      = start_i && !busy_o && (req_i.kind == REQ_STORE);
  assign inval_addr_o = req_i.addr;
  assign cap_addr_o   = req_q.addr;

  always_comb begin
    state_d = state_q;
    case (state_q)
      SEQ_IDLE: begin
        if (start_i) begin
          state_d = (req_i.size == SZ_BYTE) ? SEQ_LAST : SEQ_XFER;
        end
      end
      SEQ_XFER: begin
        if (cnt_nxt == req_q.size) begin
          state_d = SEQ_LAST;
        end
      end
      SEQ_LAST: state_d = SEQ_IDLE;
      default:  state_d = SEQ_IDLE;
    endcase
  end

  // --------------------------------------------------
  // control
  // reads finish one cycle after the last address, stores with it
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= SEQ_IDLE;
      cnt_q    <= 2'd0;
      ram_wr_o <= 1'b0;
      cap_o    <= 1'b0;
      finish_o <= 1'b0;
    end else begin
      state_q  <= state_d;
      cap_o    <= busy_o && reading;
      finish_o <= reading ? (state_q == SEQ_LAST) : (state_d == SEQ_LAST);
      if (!busy_o && start_i) begin
        cnt_q    <= 2'd0;
        ram_wr_o <= (req_i.kind == REQ_STORE);
      end else if (state_q == SEQ_XFER) begin
        cnt_q <= cnt_nxt;
      end else if (state_q == SEQ_LAST) begin
        ram_wr_o <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // address, write byte and capture tags
  always_ff @(posedge clk) begin
    cap_lane_o <= cnt_q;
    cap_kind_o <= kind_cur;
    if (!busy_o && start_i) begin
      req_q   <= req_i;
      ram_a_o <= req_i.addr;
      ram_d_o <= req_i.wdata[BYTE_W-1:0];
    end else if (state_q == SEQ_XFER) begin
      ram_a_o <= ram_a_o + addr_t'(1);
      ram_d_o <= req_q.wdata[cnt_nxt*BYTE_W +: BYTE_W];
    end
  end

endmodule

`default_nettype wire

// ==== mct_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module mct_icache import mct_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  icache_idx_t look_idx_i,
  input  icache_tag_t look_tag_i,
  output logic        hit_o,
  output word_t       data_o,
  input  logic        fill_i,
  input  icache_idx_t fill_idx_i,
  input  icache_tag_t fill_tag_i,
  input  word_t       fill_word_i,
  input  logic        inval_i,
  input  addr_t       inval_addr_i
);

  icache_tag_t             tag_q  [ICACHE_LINES];
  word_t                   data_q [ICACHE_LINES];
  logic [ICACHE_LINES-1:0] valid_q;

  addr_t       inval_end;
  icache_idx_t inval_idx_lo;
  icache_idx_t inval_idx_hi;
  icache_tag_t inval_tag_lo;
  icache_tag_t inval_tag_hi;
  logic        kill_lo;
  logic        kill_hi;

  // combinational lookup
  assign hit_o  = valid_q[look_idx_i] && (tag_q[look_idx_i] == look_tag_i);
  assign data_o = data_q[look_idx_i];

  // --------------------------------------------------
  // store snoop
  // a store of up to four bytes touches the words of its first and last byte
  assign inval_end    = inval_addr_i + addr_t'(3);
  assign inval_idx_lo = icache_idx(inval_addr_i);
  assign inval_tag_lo = icache_tag(inval_addr_i);
  assign inval_idx_hi = icache_idx(inval_end);
  assign inval_tag_hi = icache_tag(inval_end);

  assign kill_lo = inval_i && (tag_q[inval_idx_lo] == inval_tag_lo);
  assign kill_hi = inval_i && (tag_q[inval_idx_hi] == inval_tag_hi);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      if (kill_lo) begin
        valid_q[inval_idx_lo] <= 1'b0;
      end
      if (kill_hi) begin
        valid_q[inval_idx_hi] <= 1'b0;
      end
      if (fill_i) begin
        valid_q[fill_idx_i] <= 1'b1;
      end
    end
  end

  // tag and data storage
  always_ff @(posedge clk) begin
    if (fill_i) begin
      tag_q[fill_idx_i]  <= fill_tag_i;
      data_q[fill_idx_i] <= fill_word_i;
    end
  end

endmodule

`default_nettype wire

// ==== mct_pkg.sv ====
`default_nettype none

package mct_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;
  localparam int BYTE_W = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [BYTE_W-1:0] byte_t;

  // value is the index of the last byte of the transfer
  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd3
  } mem_size_e;

  typedef enum logic [1:0] {
    REQ_FETCH = 2'd0,
    REQ_LOAD  = 2'd1,
    REQ_STORE = 2'd2
  } req_kind_e;

  // one decoded request, 68 bits
  typedef struct packed {
    req_kind_e kind;
    addr_t     addr;
    word_t     wdata;
    mem_size_e size;
  } mem_req_t;

  // --------------------------------------------------
  // instruction cache geometry
  localparam int ICACHE_IDX_W   = 8;
  localparam int ICACHE_TAG_W   = 7;
  localparam int ICACHE_LINES   = 1 << ICACHE_IDX_W;
  localparam int ICACHE_IDX_LSB = 2;
  localparam int ICACHE_TAG_LSB = ICACHE_IDX_LSB + ICACHE_IDX_W;

  typedef logic [ICACHE_IDX_W-1:0] icache_idx_t;
  typedef logic [ICACHE_TAG_W-1:0] icache_tag_t;

  // index from address bits 9 to 2
  function automatic icache_idx_t icache_idx(input addr_t addr);
    return addr[ICACHE_IDX_LSB +: ICACHE_IDX_W];
  endfunction

  // tag from address bits 16 to 10
  function automatic icache_tag_t icache_tag(input addr_t addr);
    return addr[ICACHE_TAG_LSB +: ICACHE_TAG_W];
  endfunction

  // --------------------------------------------------
  // byte sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE = 2'd0,
    SEQ_XFER = 2'd1,
    SEQ_LAST = 2'd2
  } seq_state_e;

endpackage

`default_nettype wire

// ==== mct_req_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mct_req_decode import mct_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        if_e_i,
  input  addr_t       if_a_i,
  input  logic        mm_e_i,
  input  addr_t       mm_a_i,
  input  logic        mm_wr_i,
  input  mem_size_e   mm_size_i,
  input  word_t       mm_n_i,
  input  logic        busy_i,
  input  logic        done_i,
  input  logic        hit_i,
  input  word_t       hit_word_i,
  output icache_idx_t look_idx_o,
  output icache_tag_t look_tag_o,
  output logic        start_o,
  output mem_req_t    req_o,
  output logic        hit_o,
  output word_t       hit_word_o
);

  logic     wait_q;
  logic     accept;
  logic     take_data;
  logic     take_hit;
  mem_req_t req_d;

  // cache probe always follows the fetch port
  assign look_idx_o = icache_idx(if_a_i);
  assign look_tag_o = icache_tag(if_a_i);

  // one request in flight, nothing new while an ok pulse is showing
  assign accept    = !wait_q && !busy_i && !done_i && (mm_e_i || if_e_i);
  assign take_data = mm_e_i;
  assign take_hit  = !take_data && hit_i;

  // data port wins over fetch
  always_comb begin
    if (take_data) begin
      req_d.kind  = mm_wr_i ? REQ_STORE : REQ_LOAD;
      req_d.addr  = mm_a_i;
      req_d.wdata = mm_n_i;
      req_d.size  = mm_size_i;
    end else begin
      req_d.kind  = REQ_FETCH;
      req_d.addr  = if_a_i;
      req_d.wdata = '0;
      req_d.size  = SZ_WORD;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_q  <= 1'b0;
      start_o <= 1'b0;
      hit_o   <= 1'b0;
    end else begin
      start_o <= accept && !take_hit;
      hit_o   <= accept && take_hit;
      if (accept) begin
        wait_q <= 1'b1;
      end else if (done_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  // request and cached word held for the downstream blocks
  always_ff @(posedge clk) begin
    if (accept) begin
      req_o      <= req_d;
      hit_word_o <= hit_word_i;
    end
  end

endmodule

`default_nettype wire

// ==== mct_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mct_top import mct_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  // fetch port
  input  logic      if_e_i,
  input  addr_t     if_a_i,
  output logic      if_ok_o,
  output word_t     if_n_o,
  output logic      cache_hit_o,
  // data port
  input  logic      mm_e_i,
  input  addr_t     mm_a_i,
  input  logic      mm_wr_i,
  input  mem_size_e mm_size_i,
  input  word_t     mm_n_i,
  output logic      mm_ok_o,
  output word_t     mm_n_o,
  // byte ram
  output addr_t     ram_a_o,
  output logic      ram_wr_o,
  output byte_t     ram_d_o,
  input  byte_t     ram_d_i
);

  icache_idx_t look_idx;
  icache_tag_t look_tag;
  logic        look_hit;
  word_t       look_word;
  logic        start;
  mem_req_t    req;
  logic        hit;
  word_t       hit_word;
  logic        busy;
  logic        done;
  logic        cap;
  logic [1:0]  cap_lane;
  req_kind_e   cap_kind;
  addr_t       cap_addr;
  logic        finish;
  logic        inval;
  addr_t       inval_addr;
  logic        fill;
  icache_idx_t fill_idx;
  icache_tag_t fill_tag;
  word_t       fill_word;

  // either ok pulse ends the request in flight
  assign done = if_ok_o || mm_ok_o;

  mct_req_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .if_e_i     (if_e_i),
    .if_a_i     (if_a_i),
    .mm_e_i     (mm_e_i),
    .mm_a_i     (mm_a_i),
    .mm_wr_i    (mm_wr_i),
    .mm_size_i  (mm_size_i),
    .mm_n_i     (mm_n_i),
    .busy_i     (busy),
    .done_i     (done),
    .hit_i      (look_hit),
    .hit_word_i (look_word),
    .look_idx_o (look_idx),
    .look_tag_o (look_tag),
    .start_o    (start),
    .req_o      (req),
    .hit_o      (hit),
    .hit_word_o (hit_word)
  );

  mct_icache u_icache (
    .clk          (clk),
    .rst          (rst),
    .look_idx_i   (look_idx),
    .look_tag_i   (look_tag),
    .hit_o        (look_hit),
    .data_o       (look_word),
    .fill_i       (fill),
    .fill_idx_i   (fill_idx),
    .fill_tag_i   (fill_tag),
    .fill_word_i  (fill_word),
    .inval_i      (inval),
    .inval_addr_i (inval_addr)
  );

  mct_byte_seq u_seq (
    .clk          (clk),
    .rst          (rst),
    .start_i      (start),
    .req_i        (req),
    .busy_o       (busy),
    .ram_a_o      (ram_a_o),
    .ram_wr_o     (ram_wr_o),
    .ram_d_o      (ram_d_o),
    .cap_o        (cap),
    .cap_lane_o   (cap_lane),
    .cap_kind_o   (cap_kind),
    .cap_addr_o   (cap_addr),
    .finish_o     (finish),
    .inval_o      (inval),
    .inval_addr_o (inval_addr)
  );

  mct_word_assemble u_assemble (
    .clk         (clk),
    .rst         (rst),
    .cap_i       (cap),
    .cap_lane_i  (cap_lane),
    .cap_kind_i  (cap_kind),
    .cap_addr_i  (cap_addr),
    .finish_i    (finish),
    .hit_i       (hit),
    .hit_word_i  (hit_word),
    .ram_d_i     (ram_d_i),
    .fill_o      (fill),
    .fill_idx_o  (fill_idx),
    .fill_tag_o  (fill_tag),
    .fill_word_o (fill_word),
    .if_ok_o     (if_ok_o),
    .if_n_o      (if_n_o),
    .cache_hit_o (cache_hit_o),
    .mm_ok_o     (mm_ok_o),
    .mm_n_o      (mm_n_o)
  );

endmodule

`default_nettype wire

// ==== mct_word_assemble.sv ====
`timescale 1ns/1ps
`default_nettype none

module mct_word_assemble import mct_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        cap_i,
  input  logic [1:0]  cap_lane_i,
  input  req_kind_e   cap_kind_i,
  input  addr_t       cap_addr_i,
  input  logic        finish_i,
  input  logic        hit_i,
  input  word_t       hit_word_i,
  input  byte_t       ram_d_i,
  output logic        fill_o,
  output icache_idx_t fill_idx_o,
  output icache_tag_t fill_tag_o,
  output word_t       fill_word_o,
  output logic        if_ok_o,
  output word_t       if_n_o,
  output logic        cache_hit_o,
  output logic        mm_ok_o,
  output word_t       mm_n_o
);

  word_t word_q;
  word_t word_d;
  addr_t fetch_addr_q;
  logic  first_byte;
  logic  fin_fetch;
  logic  fin_data;

  assign first_byte = cap_i && (cap_lane_i == 2'd0);

  // incoming byte merged into its lane, lane 0 starts a cleared word
  always_comb begin
    word_d = first_byte ? '0 : word_q;
    if (cap_i) begin
      word_d[cap_lane_i*BYTE_W +: BYTE_W] = ram_d_i;
    end
  end

  assign fin_fetch = finish_i && (cap_kind_i == REQ_FETCH);
  assign fin_data  = finish_i && (cap_kind_i != REQ_FETCH);

  // fill leaves with the last byte so the line is valid alongside if_ok_o
  assign fill_o      = fin_fetch;
  assign fill_idx_o  = icache_idx(fetch_addr_q);
  assign fill_tag_o  = icache_tag(fetch_addr_q);
  assign fill_word_o = word_d;

  always_ff @(posedge clk) begin
    if (cap_i) begin
      word_q <= word_d;
    end
    if (first_byte && cap_kind_i == REQ_FETCH) begin
      fetch_addr_q <= cap_addr_i;
    end
  end

  // --------------------------------------------------
  // completion pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      if_ok_o     <= 1'b0;
      mm_ok_o     <= 1'b0;
      cache_hit_o <= 1'b0;
    end else begin
      if_ok_o <= hit_i || fin_fetch;
      mm_ok_o <= fin_data;
      if (hit_i) begin
        cache_hit_o <= 1'b1;
      end else if (fin_fetch) begin
        cache_hit_o <= 1'b0;
      end
    end
  end

  // result words
  always_ff @(posedge clk) begin
    if (hit_i) begin
      if_n_o <= hit_word_i;
    end else if (fin_fetch) begin
      if_n_o <= word_d;
    end
    if (fin_data && cap_kind_i == REQ_LOAD) begin
      mm_n_o <= word_d;
    end
  end

endmodule

`default_nettype wire

// ==== tb_byte_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_byte_ram import mct_pkg::*; (
  input  logic  clk,
  input  addr_t addr_i,
  input  logic  wr_i,
  input  byte_t wdata_i,
  output byte_t rdata_o
);

  localparam int RAM_AW = 16;

  byte_t mem [1 << RAM_AW];

  // start contents, every address bit plays a part
  function automatic byte_t fill_byte(input logic [RAM_AW-1:0] a);
    return (a[7:0] * 8'd29) ^ a[15:8] ^ 8'h6c;
  endfunction

  initial begin
    for (int i = 0; i < (1 << RAM_AW); i++) begin
      mem[i] = fill_byte(i[RAM_AW-1:0]);
    end
  end

  // read data one cycle after the address
  always @(posedge clk) begin
    if (wr_i) begin
      mem[addr_i[RAM_AW-1:0]] <= wdata_i;
    end
    rdata_o <= mem[addr_i[RAM_AW-1:0]];
  end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // reset seen by the DUT on the first three rising edges
  initial begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb_mct.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mct import mct_pkg::*; ();

  localparam int TIMEOUT_CYC = 40;
  localparam int RAM_BYTES   = 65536;

  typedef enum logic [1:0] {
    OP_FETCH = 2'd0,
    OP_LOAD  = 2'd1,
    OP_STORE = 2'd2,
    OP_BOTH  = 2'd3
  } op_kind_e;

  // one table row
  typedef struct packed {
    op_kind_e  kind;
    addr_t     addr;
    mem_size_e size;
    word_t     wdata;
    logic      hit;
  } op_t;

  logic      clk;
  logic      rst;
  logic      if_e_i;
  addr_t     if_a_i;
  logic      if_ok_o;
  word_t     if_n_o;
  logic      cache_hit_o;
  logic      mm_e_i;
  addr_t     mm_a_i;
  logic      mm_wr_i;
  mem_size_e mm_size_i;
  word_t     mm_n_i;
  logic      mm_ok_o;
  word_t     mm_n_o;
  addr_t     ram_a_o;
  logic      ram_wr_o;
  byte_t     ram_d_o;
  byte_t     ram_d_i;

  op_t         ops [$];
  int          n_fixed;
  logic [31:0] lcg_state;
  byte_t       mirror [RAM_BYTES];
  icache_tag_t model_tag [ICACHE_LINES];
  logic        model_valid [ICACHE_LINES];

  tb_clk_gen u_clk (
    .clk_o (clk),
    .rst_o (rst)
  );

  mct_top dut (
    .clk         (clk),
    .rst         (rst),
    .if_e_i      (if_e_i),
    .if_a_i      (if_a_i),
    .if_ok_o     (if_ok_o),
    .if_n_o      (if_n_o),
    .cache_hit_o (cache_hit_o),
    .mm_e_i      (mm_e_i),
    .mm_a_i      (mm_a_i),
    .mm_wr_i     (mm_wr_i),
    .mm_size_i   (mm_size_i),
    .mm_n_i      (mm_n_i),
    .mm_ok_o     (mm_ok_o),
    .mm_n_o      (mm_n_o),
    .ram_a_o     (ram_a_o),
    .ram_wr_o    (ram_wr_o),
    .ram_d_o     (ram_d_o),
    .ram_d_i     (ram_d_i)
  );

  tb_byte_ram u_ram (
    .clk     (clk),
    .addr_i  (ram_a_o),
    .wr_i    (ram_wr_o),
    .wdata_i (ram_d_o),
    .rdata_o (ram_d_i)
  );

  // --------------------------------------------------
  // reporting and compare tasks
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_cycles(input string name, input int exp, input int act);
    if (act != exp) begin
      stop_on_error($sformatf("FAIL %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  // --------------------------------------------------
  // reference models
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic icache_idx_t line_index(input addr_t a);
    return a[9:2];
  endfunction

  function automatic icache_tag_t line_tag(input addr_t a);
    return a[16:10];
  endfunction

  function automatic logic model_hit(input addr_t a);
    return model_valid[line_index(a)] && (model_tag[line_index(a)] == line_tag(a));
  endfunction

  task automatic model_fill(input addr_t a);
    model_tag[line_index(a)]   = line_tag(a);
    model_valid[line_index(a)] = 1'b1;
  endtask

  task automatic clear_line(input addr_t a);
    if (model_tag[line_index(a)] == line_tag(a)) begin
      model_valid[line_index(a)] = 1'b0;
    end
  endtask

  // a store hits at most the words of its first and last byte
  task automatic model_invalidate(input addr_t a, input mem_size_e sz);
    clear_line(a);
    clear_line(a + addr_t'(sz));
  endtask

  // little-endian and zero-extended above the last byte
  function automatic word_t mirror_read(input addr_t a, input mem_size_e sz);
    word_t w;
    addr_t b;
    w = '0;
    for (int i = 0; i <= int'(sz); i++) begin
      b = a + addr_t'(i);
      w[i*8 +: 8] = mirror[b[15:0]];
    end
    return w;
  endfunction

  task automatic mirror_write(input addr_t a, input mem_size_e sz, input word_t wd);
    addr_t b;
    for (int i = 0; i <= int'(sz); i++) begin
      b = a + addr_t'(i);
      mirror[b[15:0]] = wd[i*8 +: 8];
    end
  endtask

  function automatic string op_name(input op_kind_e k);
    case (k)
      OP_FETCH: return "fetch";
      OP_LOAD:  return "load";
      OP_STORE: return "store";
      default:  return "fetch+load";
    endcase
  endfunction

  // --------------------------------------------------
  // port drivers and waits
  task automatic drive_ports(input logic fetch_en, input logic data_en, input addr_t a,
                             input logic wr, input mem_size_e sz, input word_t wd);
    @(posedge clk);
    if_e_i    <= fetch_en;
    if_a_i    <= a;
    mm_e_i    <= data_en;
    mm_a_i    <= a;
    mm_wr_i   <= wr;
    mm_size_i <= sz;
    mm_n_i    <= wd;
  endtask

  task automatic release_data;
    @(posedge clk);
    mm_e_i <= 1'b0;
  endtask

  task automatic release_ports;
    @(posedge clk);
    if_e_i <= 1'b0;
    mm_e_i <= 1'b0;
  endtask

  task automatic wait_reset;
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT_CYC) begin
        stop_on_error("timeout: reset was never released");
      end
    end while (rst);
  endtask

  // count cycles and write beats until the ok pulse
  task automatic wait_pulse(input string what, input logic data_side,
                            output int lat, output int beats);
    int   n;
    logic seen;
    n     = 0;
    seen  = 1'b0;
    beats = 0;
    while (!seen) begin
      @(negedge clk);
      n++;
      if (ram_wr_o) begin
        beats++;
      end
      if (data_side) begin
        if (if_ok_o) begin
          stop_on_error({what, ": if_ok_o pulsed while the data request was pending"});
        end
        seen = mm_ok_o;
      end else begin
        seen = if_ok_o;
      end
      if (!seen && n >= TIMEOUT_CYC) begin
        stop_on_error($sformatf("timeout: %s got no %s within %0d cycles", what,
                                data_side ? "mm_ok_o" : "if_ok_o", TIMEOUT_CYC));
      end
    end
    // drive edge and acceptance edge come before cycle 0
    lat = n - 2;
  endtask

  task automatic add_op(input op_kind_e k, input addr_t a, input mem_size_e sz,
                        input word_t wd, input logic h);
    op_t op;
    op.kind  = k;
    op.addr  = a;
    op.size  = sz;
    op.wdata = wd;
    op.hit   = h;
    ops.push_back(op);
  endtask

  // --------------------------------------------------
  // one table row
  task automatic run_op(input int idx, input op_t op, input logic exp_hit);
    string name;
    int    lat;
    int    beats;
    name = $sformatf("op%0d %s %h", idx, op_name(op.kind), op.addr);
    case (op.kind)
      OP_FETCH: begin
        drive_ports(1'b1, 1'b0, op.addr, 1'b0, SZ_WORD, '0);
        wait_pulse(name, 1'b0, lat, beats);
        check_word(name, mirror_read(op.addr, SZ_WORD), if_n_o);
        check_flag({name, " hit"}, exp_hit, cache_hit_o);
        check_cycles({name, " latency"}, exp_hit ? 1 : 6, lat);
        release_ports;
        model_fill(op.addr);
      end
      OP_LOAD: begin
        drive_ports(1'b0, 1'b1, op.addr, 1'b0, op.size, '0);
        wait_pulse(name, 1'b1, lat, beats);
        check_word(name, mirror_read(op.addr, op.size), mm_n_o);
        check_cycles({name, " latency"}, int'(op.size) + 3, lat);
        release_ports;
      end
      OP_STORE: begin
        drive_ports(1'b0, 1'b1, op.addr, 1'b1, op.size, op.wdata);
        wait_pulse(name, 1'b1, lat, beats);
        check_cycles({name, " latency"}, int'(op.size) + 2, lat);
        check_cycles({name, " write beats"}, int'(op.size) + 1, beats);
        release_ports;
        mirror_write(op.addr, op.size, op.wdata);
        model_invalidate(op.addr, op.size);
      end
      default: begin
        // data side must finish first
        drive_ports(1'b1, 1'b1, op.addr, 1'b0, SZ_WORD, '0);
        wait_pulse({name, " data"}, 1'b1, lat, beats);
        check_word({name, " data"}, mirror_read(op.addr, SZ_WORD), mm_n_o);
        check_cycles({name, " data latency"}, 6, lat);
        release_data;
        wait_pulse({name, " fetch"}, 1'b0, lat, beats);
        check_word({name, " fetch"}, mirror_read(op.addr, SZ_WORD), if_n_o);
        check_flag({name, " hit"}, exp_hit, cache_hit_o);
        check_cycles({name, " fetch latency"}, exp_hit ? 1 : 6, lat);
        release_ports;
        model_fill(op.addr);
      end
    endcase
  endtask

  // --------------------------------------------------
  // main sequence
  initial begin
    addr_t a;
    logic  exp_hit;
    if_e_i    <= 1'b0;
    if_a_i    <= '0;
    mm_e_i    <= 1'b0;
    mm_a_i    <= '0;
    mm_wr_i   <= 1'b0;
    mm_size_i <= SZ_WORD;
    mm_n_i    <= '0;
    for (int i = 0; i < ICACHE_LINES; i++) begin
      model_tag[i]   = '0;
      model_valid[i] = 1'b0;
    end

    // miss then hit
    add_op(OP_FETCH, 32'h0000_0300, SZ_WORD, '0, 1'b0);
    add_op(OP_FETCH, 32'h0000_0300, SZ_WORD, '0, 1'b1);
    // stores at mixed offsets read back as words
    add_op(OP_STORE, 32'h0000_0200, SZ_WORD, 32'h1122_3344, 1'b0);
    add_op(OP_LOAD,  32'h0000_0200, SZ_WORD, '0, 1'b0);
    add_op(OP_STORE, 32'h0000_0205, SZ_HALF, 32'h0000_beef, 1'b0);
    add_op(OP_LOAD,  32'h0000_0204, SZ_WORD, '0, 1'b0);
    add_op(OP_STORE, 32'h0000_020b, SZ_BYTE, 32'hffff_ffa5, 1'b0);
    add_op(OP_LOAD,  32'h0000_0208, SZ_WORD, '0, 1'b0);
    add_op(OP_LOAD,  32'h0000_0206, SZ_HALF, '0, 1'b0);
    add_op(OP_LOAD,  32'h0000_020b, SZ_BYTE, '0, 1'b0);
    add_op(OP_STORE, 32'h0000_0211, SZ_WORD, 32'hcafe_1234, 1'b0);
    add_op(OP_LOAD,  32'h0000_0210, SZ_WORD, '0, 1'b0);
    add_op(OP_LOAD,  32'h0000_0214, SZ_WORD, '0, 1'b0);
    // coherence with stores into cached lines
    add_op(OP_FETCH, 32'h0000_0400, SZ_WORD, '0, 1'b0);
    add_op(OP_FETCH, 32'h0000_0300, SZ_WORD, '0, 1'b1);
    add_op(OP_STORE, 32'h0000_0300, SZ_WORD, 32'h0bad_f00d, 1'b0);
    add_op(OP_FETCH, 32'h0000_0300, SZ_WORD, '0, 1'b0);
    add_op(OP_FETCH, 32'h0000_0400, SZ_WORD, '0, 1'b1);
    add_op(OP_STORE, 32'h0000_0402, SZ_HALF, 32'h0000_7777, 1'b0);
    add_op(OP_FETCH, 32'h0000_0400, SZ_WORD, '0, 1'b0);
    add_op(OP_FETCH, 32'h0000_0300, SZ_WORD, '0, 1'b1);
    // both ports at once
    add_op(OP_BOTH,  32'h0000_0208, SZ_WORD, '0, 1'b0);
    add_op(OP_BOTH,  32'h0000_0300, SZ_WORD, '0, 1'b1);
    n_fixed = ops.size();

    // random fetches over twelve words with the hit flag from the model
    lcg_state = 32'd83;
    repeat (20) begin
      lcg_state = lcg_next(lcg_state);
      a = 32'h0000_1000 + addr_t'(((lcg_state >> 16) % 12) * 4);
      add_op(OP_FETCH, a, SZ_WORD, '0, 1'b0);
    end

    wait_reset;
    check_flag("reset if_ok_o", 1'b0, if_ok_o);
    check_flag("reset mm_ok_o", 1'b0, mm_ok_o);
    check_flag("reset cache_hit_o", 1'b0, cache_hit_o);
    check_flag("reset ram_wr_o", 1'b0, ram_wr_o);
    for (int i = 0; i < RAM_BYTES; i++) begin
      mirror[i] = u_ram.mem[i];
    end

    for (int i = 0; i < ops.size(); i++) begin
      exp_hit = (i < n_fixed) ? ops[i].hit : model_hit(ops[i].addr);
      run_op(i, ops[i], exp_hit);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
